// ==== project.f ====
rtl/exu_cfg_pkg.sv
rtl/exu_types_pkg.sv
rtl/exu_operand_sel.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_div.sv
rtl/exu_wb_arb.sv
rtl/exu_top.sv
sim/tb_exu.sv

// ==== Makefile ====
# Verilator build and run for the execute unit testbench

VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_exu.sv ====
// Execute unit testbench
// Random issue stream checked against a cycle model

`timescale 1ns/1ps

module tb_exu;

   import exu_cfg_pkg::*;
   import exu_types_pkg::*;

   localparam int NUM_OPS    = 1500;
   localparam int MAX_CYCLES = NUM_OPS * (DIV_CYCLES + 4) + 100;

   logic            clk;
   logic            i_rst_n;
   issue_t          i_issue;
   logic [XLEN-1:0] i_gpr_rs1;
   logic [XLEN-1:0] i_gpr_rs2;
   logic [XLEN-1:0] i_lsu_result;
   flush_t          i_flush_lower;
   wb_t             o_wb;
   flush_t          o_flush;
   logic            o_div_busy;

   logic [31:0]     seed;
   int              cycle_cnt = 0;
   wb_t             x_s1;        // ALU/MUL result one edge after issue
   wb_t             x_s2;        // ALU/MUL result due on o_wb
   flush_t          br_s1;       // Branch redirect due on o_flush
   logic            div_busy;
   logic            div_pend;    // Divide result not yet written back
   wb_t             div_res;
   int              div_age;     // Cycles since the divide issued

   exu_top uut (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_issue       (i_issue),
      .i_gpr_rs1     (i_gpr_rs1),
      .i_gpr_rs2     (i_gpr_rs2),
      .i_lsu_result  (i_lsu_result),
      .i_flush_lower (i_flush_lower),
      .o_wb          (o_wb),
      .o_flush       (o_flush),
      .o_div_busy    (o_div_busy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES) begin
         $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
         stop_on_error();
      end
   end

   function automatic logic [31:0] rand32();
      seed = seed * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
      return seed;
   endfunction

   task automatic stop_on_error();
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic report_failure(input string what);
      $display("Error: %s at time %0t", what, $time);
      stop_on_error();
   endtask

   task automatic check_wb(input string name, input wb_t exp, input wb_t act);
      if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_flush(input string name, input flush_t exp, input flush_t act);
      if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   function automatic logic [1:0] byp_code(input logic [1:0] r);
      if (r == 2'b10) return BYP_WB;
      if (r == 2'b11) return BYP_LSU;
      return BYP_NONE;   // Half of the picks use no bypass
   endfunction

   function automatic operands_t select_operands(input issue_t iss, input logic [XLEN-1:0] g1,
                                                 input logic [XLEN-1:0] g2,
                                                 input logic [XLEN-1:0] wbd,
                                                 input logic [XLEN-1:0] lsu);
      operands_t o;
      if (iss.rs1_byp == BYP_WB) o.a = wbd;
      else if (iss.rs1_byp == BYP_LSU) o.a = lsu;
      else if (iss.sel_pc) o.a = {iss.pc, 1'b0};
      else if (iss.rs1_en) o.a = g1;
      else o.a = '0;
      if (iss.rs2_byp == BYP_WB) o.b = wbd;
      else if (iss.rs2_byp == BYP_LSU) o.b = lsu;
      else if (iss.sel_imm) o.b = iss.imm;
      else if (iss.rs2_en) o.b = g2;
      else o.b = '0;
      return o;
   endfunction

   function automatic logic [XLEN-1:0] alu_result(input alu_ctl_t c, input operands_t o);
      logic lt;
      lt = c.unsign ? (o.a < o.b) : ($signed(o.a) < $signed(o.b));
      if (c.add) return o.a + o.b;
      if (c.sub) return o.a - o.b;
      if (c.land) return o.a & o.b;
      if (c.lor) return o.a | o.b;
      if (c.lxor) return o.a ^ o.b;
      return {{(XLEN-1){1'b0}}, lt};   // SLT or SLTU
   endfunction

   function automatic flush_t branch_flush(input issue_t iss, input operands_t o);
      alu_ctl_t c;
      logic     lt;
      logic     taken;
      flush_t   f;
      c     = iss.op.alu;
      lt    = c.unsign ? (o.a < o.b) : ($signed(o.a) < $signed(o.b));
      taken = (c.cond == COND_EQ) ? (o.a == o.b) :
              (c.cond == COND_NE) ? (o.a != o.b) :
              (c.cond == COND_LT) ? lt : !lt;
      f.valid = (taken != c.pred_taken);
      if (taken) f.path = iss.pc + PC_W'($signed(iss.br_offset));
      else f.path = iss.pc + 31'd2;   // Next instruction, in halfwords
      return f;
   endfunction

   function automatic logic [XLEN-1:0] mul_result(input md_ctl_t m, input operands_t o);
      logic [63:0] ea;
      logic [63:0] eb;
      logic [63:0] p;
      ea = (m.rs1_sign && o.a[31]) ? {32'hFFFF_FFFF, o.a} : {32'h0, o.a};
      eb = (m.rs2_sign && o.b[31]) ? {32'hFFFF_FFFF, o.b} : {32'h0, o.b};
      p  = ea * eb;   // Exact modulo 2^64 for every sign mix
      return m.low ? p[31:0] : p[63:32];
   endfunction

   function automatic logic [XLEN-1:0] div_result(input md_ctl_t m, input operands_t o);
      logic [XLEN-1:0] q;
      logic [XLEN-1:0] r;
      if (o.b == '0) begin
         q = '1;
         r = o.a;
      end else if (m.unsign) begin
         q = o.a / o.b;
         r = o.a % o.b;
      end else if (o.a == 32'h8000_0000 && o.b == '1) begin
         q = o.a;   // Signed overflow
         r = '0;
      end else begin
         q = $signed(o.a) / $signed(o.b);
         r = $signed(o.a) % $signed(o.b);
      end
      return m.rem ? r : q;
   endfunction

   task automatic make_issue(input logic allow, input logic div_ok, output issue_t iss);
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      alu_ctl_t    c;
      md_ctl_t     m;
      r1 = rand32();
      r2 = rand32();
      r3 = rand32();
      iss = '0;
      iss.valid = allow && (r1[2:0] != 3'd0);
      if (div_ok && r1[5:3] < 3'd2) iss.unit = UNIT_DIV;
      else if (r1[6]) iss.unit = UNIT_MUL;
      else iss.unit = UNIT_ALU;
      iss.rd        = r1[11:7];
      iss.br_offset = r1[23:12];
      iss.pc        = r2[PC_W-1:0];
      iss.imm       = rand32();
      iss.rs1_byp   = byp_code(r3[1:0]);
      iss.rs2_byp   = byp_code(r3[3:2]);
      iss.rs1_en    = r3[4];
      iss.rs2_en    = r3[5];
      iss.sel_pc    = r3[6] & r3[7];
      iss.sel_imm   = r3[8];
      if (iss.unit == UNIT_DIV && r3[10:9] != 2'd0) begin   // Let corner GPR values through
         iss.rs1_byp = BYP_NONE;
         iss.rs2_byp = BYP_NONE;
         iss.sel_pc  = 1'b0;
         iss.sel_imm = 1'b0;
         iss.rs1_en  = 1'b1;
         iss.rs2_en  = 1'b1;
      end
      c = '0;
      case (r3[13:11])
         3'd0: c.add = 1'b1;
         3'd1: c.sub = 1'b1;
         3'd2: c.land = 1'b1;
         3'd3: c.lor = 1'b1;
         3'd4: c.lxor = 1'b1;
         3'd5: c.slt = 1'b1;
         default: c.branch = 1'b1;
      endcase
      c.unsign     = r3[14];
      c.cond       = r3[16:15];
      c.pred_taken = r3[17];
      m            = '0;
      m.low        = r3[18];
      m.rs1_sign   = r3[19];
      m.rs2_sign   = r3[20];
      m.rem        = r3[21];
      m.unsign     = r3[22];
      if (iss.unit == UNIT_ALU) iss.op.alu = c;
      else iss.op.md = m;
   endtask

   // One clock: check registered outputs, drive, check flush, advance the model
   task automatic run_cycle(input logic allow);
      logic [31:0]     r;
      logic [XLEN-1:0] gpr1;
      logic [XLEN-1:0] gpr2;
      logic [XLEN-1:0] lsu;
      logic            granted;
      logic            kill;
      wb_t             exp_wb;
      wb_t             res;
      flush_t          exp_flush;
      flush_t          ext;
      issue_t          iss;
      operands_t       ops;

      @(negedge clk);
      check_bit("o_div_busy", div_busy, o_div_busy);
      granted = 1'b0;
      exp_wb  = '0;
      if (x_s2.valid) begin
         exp_wb = x_s2;
      end else if (o_wb.valid) begin
         if (!div_pend) report_failure("o_wb valid with no result outstanding");
         if (div_age < DIV_CYCLES + 1) report_failure("divide result came out too early");
         exp_wb  = div_res;
         granted = 1'b1;
      end
      check_wb("o_wb", exp_wb, o_wb);

      r    = rand32();
      kill = (r[9:5] == 5'd0);
      r    = rand32();
      ext.valid = kill;
      ext.path  = r[PC_W-1:0];
      r    = rand32();
      gpr1 = rand32();
      gpr2 = rand32();
      lsu  = rand32();
      case (r[3:0])
         4'd0: gpr2 = '0;
         4'd1: begin
            gpr1 = 32'h8000_0000;
            gpr2 = '1;
         end
         4'd2, 4'd3: gpr2 = gpr1;   // Equal operands for branches
         default: ;
      endcase
      make_issue(allow, !div_busy, iss);

      i_issue       = iss;
      i_gpr_rs1     = gpr1;
      i_gpr_rs2     = gpr2;
      i_lsu_result  = lsu;
      i_flush_lower = ext;
      ops = select_operands(iss, gpr1, gpr2, exp_wb.data, lsu);
      #1;
      exp_flush = kill ? ext : br_s1;
      check_flush("o_flush", exp_flush, o_flush);

      res = '0;
      if (kill) begin
         x_s1     = '0;
         x_s2     = '0;
         br_s1    = '0;
         div_busy = 1'b0;
         div_pend = 1'b0;
      end else begin
         x_s2  = x_s1;
         x_s1  = '0;
         br_s1 = '0;
         if (granted) begin
            div_busy = 1'b0;
            div_pend = 1'b0;
         end
         if (iss.valid) begin
            res.valid = 1'b1;
            res.unit  = iss.unit;
            res.rd    = iss.rd;
            case (iss.unit)
               UNIT_ALU: begin
                  if (iss.op.alu.branch) begin
                     br_s1 = branch_flush(iss, ops);
                  end else begin
                     res.data = alu_result(iss.op.alu, ops);
                     x_s1     = res;
                  end
               end
               UNIT_MUL: begin
                  res.data = mul_result(iss.op.md, ops);
                  x_s1     = res;
               end
               default: begin
                  res.data = div_result(iss.op.md, ops);
                  div_res  = res;
                  div_busy = 1'b1;
                  div_pend = 1'b1;
                  div_age  = 0;
               end
            endcase
         end
      end
      if (div_pend) div_age++;
   endtask

   initial begin
      seed          = 32'h5fdc_de5c;
      x_s1          = '0;
      x_s2          = '0;
      br_s1         = '0;
      div_res       = '0;
      div_busy      = 1'b0;
      div_pend      = 1'b0;
      div_age       = 0;
      i_rst_n       = 1'b0;
      i_issue       = '0;
      i_gpr_rs1     = '0;
      i_gpr_rs2     = '0;
      i_lsu_result  = '0;
      i_flush_lower = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;

      for (int i = 0; i < NUM_OPS; i++) begin
         run_cycle(1'b1);
      end
      while (div_busy || x_s1.valid || x_s2.valid) begin   // Drain outstanding results
         run_cycle(1'b0);
      end
      run_cycle(1'b0);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== rtl/exu_top.sv ====
// Integer execute unit top level

`timescale 1ns/1ps

module exu_top (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  exu_types_pkg::issue_t        i_issue,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_gpr_rs1,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_gpr_rs2,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_lsu_result,
   input  exu_types_pkg::flush_t        i_flush_lower,
   output exu_types_pkg::wb_t           o_wb,
   output exu_types_pkg::flush_t        o_flush,
   output logic                         o_div_busy
);

   import exu_cfg_pkg::*;
   import exu_types_pkg::*;

   operands_t ops;
   flush_t    flush_br;
   wb_t       req_alu;
   wb_t       req_mul;
   wb_t       req_div;
   wb_t       req_x;
   logic      grant_div;
   logic      kill;

   assign kill    = i_flush_lower.valid;
   assign o_flush = i_flush_lower.valid ? i_flush_lower : flush_br;   // Trap flush is older
   assign req_x   = (req_alu.valid ? req_alu : '0) |
                    (req_mul.valid ? req_mul : '0);   // At most one valid per cycle

   exu_operand_sel u_sel (
      .i_issue      (i_issue),
      .i_gpr_rs1    (i_gpr_rs1),
      .i_gpr_rs2    (i_gpr_rs2),
      .i_wb_data    (o_wb.data),
      .i_lsu_result (i_lsu_result),
      .o_ops        (ops)
   );

   exu_alu u_alu (.clk, .i_rst_n, .i_issue, .i_ops(ops), .i_kill(kill),
                  .o_flush_br(flush_br), .o_req(req_alu));

   exu_mul u_mul (.clk, .i_rst_n, .i_issue, .i_ops(ops), .i_kill(kill), .o_req(req_mul));

   exu_div u_div (.clk, .i_rst_n, .i_issue, .i_ops(ops), .i_cancel(kill),
                  .i_grant(grant_div), .o_busy(o_div_busy), .o_req(req_div));

   exu_wb_arb u_arb (.i_req_x(req_x), .i_req_div(req_div), .o_wb, .o_grant_div(grant_div));

   a_x_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(req_alu.valid && req_mul.valid))
      else $error("exu_top: ALU and multiplier requests overlap");

   // X path results land on the port at fixed latency unless flushed in flight
   a_alu_lat: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_issue.valid && i_issue.unit == UNIT_ALU && !i_issue.op.alu.branch && !kill)
      |-> ##ALU_LAT ((o_wb.valid && o_wb.unit == UNIT_ALU) || $past(kill, ALU_LAT - 1)))
      else $error("exu_top: ALU result missed its writeback slot");

   a_mul_lat: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_issue.valid && i_issue.unit == UNIT_MUL && !kill)
      |-> ##MUL_LAT ((o_wb.valid && o_wb.unit == UNIT_MUL) || $past(kill, MUL_LAT - 1)))
      else $error("exu_top: multiply result missed its writeback slot");

endmodule

// ==== rtl/exu_wb_arb.sv ====
// GPR writeback port arbiter

`timescale 1ns/1ps

module exu_wb_arb (
   input  exu_types_pkg::wb_t i_req_x,
   input  exu_types_pkg::wb_t i_req_div,
   output exu_types_pkg::wb_t o_wb,
   output logic               o_grant_div
);

   // Fixed-latency X path always wins and the divider waits
   assign o_grant_div = i_req_div.valid && !i_req_x.valid;

   always_comb begin
      if (i_req_x.valid) begin
         o_wb = i_req_x;
      end else if (o_grant_div) begin
         o_wb = i_req_div;
      end else begin
         o_wb = '0;
      end
   end

endmodule

// ==== rtl/exu_div.sv ====
// Iterative restoring divider

`timescale 1ns/1ps

module exu_div (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  exu_types_pkg::issue_t    i_issue,
   input  exu_types_pkg::operands_t i_ops,
   input  logic                     i_cancel,
   input  logic                     i_grant,
   output logic                     o_busy,
   output exu_types_pkg::wb_t       o_req
);

   import exu_cfg_pkg::*;
   import exu_types_pkg::*;

   localparam int CNT_W = $clog2(DIV_CYCLES);

   md_ctl_t           md;
   logic              start;
   logic              a_neg;
   logic              b_neg;
   logic [XLEN-1:0]   a_mag;
   logic [XLEN-1:0]   b_mag;

   logic              running;
   logic              done;
   logic [CNT_W-1:0]  count;
   logic [XLEN-1:0]   quot;       // Dividend shifts out as quotient shifts in
   logic [XLEN-1:0]   rem;
   logic [XLEN-1:0]   dvsr;
   logic              neg_q;
   logic              neg_r;
   logic              rem_sel;
   logic [REG_AW-1:0] rd;

   logic [XLEN:0]     shifted;
   logic              ge;
   logic [XLEN:0]     diff;
   logic [XLEN-1:0]   result;

   assign md    = i_issue.op.md;
   assign start = i_issue.valid && (i_issue.unit == UNIT_DIV) && !i_cancel;
   assign a_neg = !md.unsign && i_ops.a[XLEN-1];
   assign b_neg = !md.unsign && i_ops.b[XLEN-1];
   assign a_mag = a_neg ? -i_ops.a : i_ops.a;
   assign b_mag = b_neg ? -i_ops.b : i_ops.b;

   // One restoring step
   assign shifted = {rem, quot[XLEN-1]};
   assign ge      = (shifted >= {1'b0, dvsr});
   assign diff    = shifted - {1'b0, dvsr};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         running <= 1'b0;
         done    <= 1'b0;
         count   <= '0;
      end else if (i_cancel) begin
         running <= 1'b0;
         done    <= 1'b0;
      end else if (start) begin
         running <= 1'b1;
         done    <= 1'b0;
         count   <= CNT_W'(DIV_CYCLES - 1);
      end else if (running) begin
         count <= count - 1'b1;
         if (count == '0) begin
            running <= 1'b0;
            done    <= 1'b1;
         end
      end else if (done && i_grant) begin
         done <= 1'b0;   // Result taken by the WB port
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         quot    <= a_mag;
         rem     <= '0;
         dvsr    <= b_mag;
         neg_q   <= (a_neg ^ b_neg) && (i_ops.b != '0);   // x/0 stays all ones
         neg_r   <= a_neg;
         rem_sel <= md.rem;
         rd      <= i_issue.rd;
      end else if (running) begin
         quot <= {quot[XLEN-2:0], ge};
         rem  <= ge ? diff[XLEN-1:0] : shifted[XLEN-1:0];
      end
   end

   // MIN/-1 comes out as MIN with remainder 0 from the magnitudes alone
   always_comb begin
      if (rem_sel) begin
         result = neg_r ? -rem : rem;
      end else begin
         result = neg_q ? -quot : quot;
      end
   end

   assign o_busy      = running || done;
   assign o_req.valid = done;
   assign o_req.unit  = UNIT_DIV;
   assign o_req.rd    = rd;
   assign o_req.data  = result;

   // Issuer waits until the previous result has left the port
   a_no_issue_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_issue.valid && i_issue.unit == UNIT_DIV) |-> !o_busy)
      else $error("exu_div: divide issued while busy");

endmodule

// ==== rtl/exu_mul.sv ====
// Two-stage pipelined multiplier

`timescale 1ns/1ps

module exu_mul (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  exu_types_pkg::issue_t    i_issue,
   input  exu_types_pkg::operands_t i_ops,
   input  logic                     i_kill,
   output exu_types_pkg::wb_t       o_req
);

   import exu_cfg_pkg::*;
   import exu_types_pkg::*;

   md_ctl_t                  md;
   logic                     s1_load;
   logic signed [XLEN:0]     a_ext;
   logic signed [XLEN:0]     b_ext;
   logic signed [2*XLEN+1:0] prod;

   logic                     s1_valid;
   logic                     s1_low;
   logic [REG_AW-1:0]        s1_rd;
   logic [2*XLEN-1:0]        s1_prod;

   logic                     s2_valid;
   logic [REG_AW-1:0]        s2_rd;
   logic [XLEN-1:0]          s2_data;

   assign md      = i_issue.op.md;
   assign s1_load = i_issue.valid && (i_issue.unit == UNIT_MUL) && !i_kill;

   // 33-bit operands cover MULH, MULHSU and MULHU in one signed multiply
   assign a_ext = {md.rs1_sign & i_ops.a[XLEN-1], i_ops.a};
   assign b_ext = {md.rs2_sign & i_ops.b[XLEN-1], i_ops.b};
   assign prod  = a_ext * b_ext;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= s1_load;
         s2_valid <= s1_valid && !i_kill;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_load) begin
         s1_low  <= md.low;
         s1_rd   <= i_issue.rd;
         s1_prod <= prod[2*XLEN-1:0];
      end
      if (s1_valid) begin
         s2_rd   <= s1_rd;
         s2_data <= s1_low ? s1_prod[XLEN-1:0] : s1_prod[2*XLEN-1:XLEN];
      end
   end

   assign o_req.valid = s2_valid;
   assign o_req.unit  = UNIT_MUL;
   assign o_req.rd    = s2_rd;
   assign o_req.data  = s2_data;

endmodule

// ==== rtl/exu_alu.sv ====
// X-stage ALU and branch resolution

`timescale 1ns/1ps

module exu_alu (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  exu_types_pkg::issue_t    i_issue,
   input  exu_types_pkg::operands_t i_ops,
   input  logic                     i_kill,
   output exu_types_pkg::flush_t    o_flush_br,
   output exu_types_pkg::wb_t       o_req
);

   import exu_cfg_pkg::*;
   import exu_types_pkg::*;

   logic              x_load;
   logic              x_valid;
   alu_ctl_t          x_ctl;
   logic [REG_AW-1:0] x_rd;
   logic [PC_W-1:0]   x_pc;
   logic [11:0]       x_br_offset;
   operands_t         x_ops;

   logic [XLEN-1:0]   result;
   logic              eq;
   logic              lt;
   logic              taken;

   logic              wb_valid;
   logic [REG_AW-1:0] wb_rd;
   logic [XLEN-1:0]   wb_data;

   assign x_load = i_issue.valid && (i_issue.unit == UNIT_ALU) && !i_kill;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         x_valid  <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         x_valid  <= x_load;
         wb_valid <= x_valid && !x_ctl.branch && !i_kill;   // Branches never write back
      end
   end

   always_ff @(posedge clk) begin
      if (x_load) begin
         x_ctl       <= i_issue.op.alu;
         x_rd        <= i_issue.rd;
         x_pc        <= i_issue.pc;
         x_br_offset <= i_issue.br_offset;
         x_ops       <= i_ops;
      end
      if (x_valid) begin
         wb_rd   <= x_rd;
         wb_data <= result;
      end
   end

   always_comb begin
      eq = (x_ops.a == x_ops.b);
      if (x_ctl.unsign) begin
         lt = (x_ops.a < x_ops.b);
      end else begin
         lt = ($signed(x_ops.a) < $signed(x_ops.b));
      end

      result = ({XLEN{x_ctl.add}}  & (x_ops.a + x_ops.b)) |
               ({XLEN{x_ctl.sub}}  & (x_ops.a - x_ops.b)) |
               ({XLEN{x_ctl.land}} & (x_ops.a & x_ops.b)) |
               ({XLEN{x_ctl.lor}}  & (x_ops.a | x_ops.b)) |
               ({XLEN{x_ctl.lxor}} & (x_ops.a ^ x_ops.b)) |
               ({XLEN{x_ctl.slt}}  & XLEN'(lt));

      taken = 1'b0;
      case (x_ctl.cond)
         COND_EQ: taken = eq;
         COND_NE: taken = !eq;
         COND_LT: taken = lt;
         COND_GE: taken = !lt;
      endcase
   end

   // Redirect to the side the predictor did not pick
   assign o_flush_br.valid = x_valid && x_ctl.branch && (taken != x_ctl.pred_taken);
   assign o_flush_br.path  = taken ? (x_pc + {{(PC_W-12){x_br_offset[11]}}, x_br_offset})
                                   : (x_pc + PC_W'(2));   // PC+4 in halfwords

   assign o_req.valid = wb_valid;
   assign o_req.unit  = UNIT_ALU;
   assign o_req.rd    = wb_rd;
   assign o_req.data  = wb_data;

endmodule

// ==== rtl/exu_operand_sel.sv ====
// Operand source selection

`timescale 1ns/1ps

module exu_operand_sel (
   input  exu_types_pkg::issue_t        i_issue,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_gpr_rs1,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_gpr_rs2,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_wb_data,
   input  logic [exu_cfg_pkg::XLEN-1:0] i_lsu_result,
   output exu_types_pkg::operands_t     o_ops
);

   import exu_cfg_pkg::*;

   logic            rs1_byp_en;
   logic            rs2_byp_en;
   logic [XLEN-1:0] rs1_byp_data;
   logic [XLEN-1:0] rs2_byp_data;

   assign rs1_byp_en   = (i_issue.rs1_byp != BYP_NONE);
   assign rs2_byp_en   = (i_issue.rs2_byp != BYP_NONE);

   assign rs1_byp_data = ({XLEN{i_issue.rs1_byp == BYP_WB}}  & i_wb_data) |
                         ({XLEN{i_issue.rs1_byp == BYP_LSU}} & i_lsu_result);
   assign rs2_byp_data = ({XLEN{i_issue.rs2_byp == BYP_WB}}  & i_wb_data) |
                         ({XLEN{i_issue.rs2_byp == BYP_LSU}} & i_lsu_result);

   always_comb begin
      if (rs1_byp_en) begin
         o_ops.a = rs1_byp_data;
      end else if (i_issue.sel_pc) begin
         o_ops.a = {i_issue.pc, 1'b0};   // JAL and AUIPC
      end else if (i_issue.rs1_en) begin
         o_ops.a = i_gpr_rs1;
      end else begin
         o_ops.a = '0;
      end

      if (rs2_byp_en) begin
         o_ops.b = rs2_byp_data;
      end else if (i_issue.sel_imm) begin
         o_ops.b = i_issue.imm;
      end else if (i_issue.rs2_en) begin
         o_ops.b = i_gpr_rs2;
      end else begin
         o_ops.b = '0;
      end
   end

   // Decode picks at most one bypass source per operand
   always_comb begin
      if (i_issue.valid) begin
         assert (i_issue.rs1_byp inside {BYP_NONE, BYP_WB, BYP_LSU} &&
                 i_issue.rs2_byp inside {BYP_NONE, BYP_WB, BYP_LSU})
            else $error("exu_operand_sel: bypass select is not one-hot");
      end
   end

endmodule

// ==== rtl/exu_types_pkg.sv ====
// Execute unit shared types

package exu_types_pkg;

   import exu_cfg_pkg::*;

   // ALU view of the control word
   typedef struct packed {
      logic       add;
      logic       sub;
      logic       land;
      logic       lor;
      logic       lxor;
      logic       slt;
      logic       unsign;       // Unsigned compare for slt and branches
      logic       branch;
      logic [1:0] cond;         // COND_* encoding
      logic       pred_taken;   // Predicted direction from fetch
   } alu_ctl_t;

   // Multiply/divide view, padded to the ALU width
   typedef struct packed {
      logic [5:0] rsvd;
      logic       low;          // Low product word
      logic       rs1_sign;
      logic       rs2_sign;
      logic       rem;          // Remainder instead of quotient
      logic       unsign;       // Unsigned divide
   } md_ctl_t;

   // Same bits, decoded by the unit field
   typedef union packed {
      alu_ctl_t alu;
      md_ctl_t  md;
   } op_u;

   typedef struct packed {
      logic              valid;
      logic [1:0]        unit;
      op_u               op;
      logic [REG_AW-1:0] rd;
      logic [PC_W-1:0]   pc;
      logic [XLEN-1:0]   imm;
      logic [11:0]       br_offset;   // Halfwords, sign extended
      logic [1:0]        rs1_byp;
      logic [1:0]        rs2_byp;
      logic              rs1_en;
      logic              rs2_en;
      logic              sel_pc;
      logic              sel_imm;
   } issue_t;

   typedef struct packed {
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
   } operands_t;

   typedef struct packed {
      logic              valid;
      logic [1:0]        unit;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   data;
   } wb_t;

   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] path;
   } flush_t;

endpackage

// ==== rtl/exu_cfg_pkg.sv ====
// Execute unit configuration
// Widths, latencies and control encodings

package exu_cfg_pkg;

   localparam int XLEN       = 32;   // Data word
   localparam int REG_AW     = 5;    // GPR index
   localparam int PC_W       = 31;   // PC[31:1] with bit 0 implied
   localparam int DIV_CYCLES = 32;   // One quotient bit per step

   // Unit that owns an issued op
   localparam logic [1:0] UNIT_ALU = 2'd0;
   localparam logic [1:0] UNIT_MUL = 2'd1;
   localparam logic [1:0] UNIT_DIV = 2'd2;

   // Operand bypass select, zero or one-hot
   localparam logic [1:0] BYP_NONE = 2'b00;
   localparam logic [1:0] BYP_WB   = 2'b01;   // Own writeback value
   localparam logic [1:0] BYP_LSU  = 2'b10;   // Load result

   // Branch conditions
   localparam logic [1:0] COND_EQ = 2'd0;
   localparam logic [1:0] COND_NE = 2'd1;
   localparam logic [1:0] COND_LT = 2'd2;
   localparam logic [1:0] COND_GE = 2'd3;

   localparam int ALU_LAT = 2;   // Issue to o_wb
   localparam int MUL_LAT = 2;   // Issue to o_wb

endpackage
